// File: breakoutPkg.sv
`default_nettype none

package breakoutPkg;

   // Fixed-point format. Positions carry 6 subpixel bits.
   localparam int subBits = 6;

   typedef logic [15:0] posT;
   typedef logic [9:0] pixelT;
   typedef logic [6:0] tileT;
   typedef logic [6:0] blockIdxT;
   typedef logic [2:0] blockRowT;

   // Object sizes and playfield edges in pixels.
   localparam pixelT ballSizePixel = 10'd8;
   localparam pixelT paddleLengthPixel = 10'd64;
   localparam pixelT paddleYPixel = 10'd440;
   localparam pixelT gameBeginXPixel = 10'd16;
   localparam pixelT gameEndXPixel = 10'd624;

   // Tile grid, one tile is 8 pixels.
   localparam tileT leftWallXTile = 7'd1;
   localparam tileT rightWallXTile = 7'd78;
   localparam tileT ceilingYTile = 7'd1;
   localparam tileT blockStartXTile = 7'd4;
   localparam tileT blockStartYTile = 7'd6;
   localparam tileT paddleYTile = tileT'(paddleYPixel >> 3);
   localparam tileT lostYTile = paddleYTile + 7'd3;

   // Block grid. Blocks are 8 tiles wide and 2 tiles tall.
   localparam logic [3:0] blockColCount = 4'd9;
   localparam logic [3:0] blockRowCount = 4'd8;
   localparam blockIdxT invalidBlock = 7'd72;

   // Motion, in subpixels per step.
   localparam posT paddleSpeedSub = 16'd32;
   localparam pixelT paddleStartPixel = 10'd370;
   localparam posT launchVelX = 16'd6;
   localparam posT launchVelY = -16'sd16;
   localparam posT paddleSteerSub = 16'd4;
   localparam logic [3:0] stepsPerFrame = 4'd12;

   // Derived subpixel positions.
   localparam posT paddleStartSub = posT'(paddleStartPixel) << subBits;
   localparam posT paddleMinSub = posT'(gameBeginXPixel) << subBits;
   localparam posT paddleMaxSub = posT'(gameEndXPixel - paddleLengthPixel) << subBits;
   localparam posT ballParkOffsetSub =
      posT'((paddleLengthPixel - ballSizePixel) / 2) << subBits;
   localparam posT ballParkYSub = posT'(paddleYPixel - ballSizePixel) << subBits;

   typedef enum logic [2:0] {
      phExtrapolate,
      phNeighbors,
      phLoadX,
      phLoadY,
      phCollide,
      phUpdate,
      phStoreY
   } physPhaseT;

   typedef enum logic [1:0] {
      ballWait,
      ballInGame,
      ballLost
   } ballModeT;

endpackage

`default_nettype wire

// File: physicsIfs.sv
`timescale 1ns/1ps
`default_nettype none

// Ball state as seen by the collision logic.
interface ballIf;
   breakoutPkg::posT ballX;
   breakoutPkg::posT ballY;
   breakoutPkg::posT ballVelX;
   breakoutPkg::posT ballVelY;
   breakoutPkg::ballModeT ballMode;

   modport owner (output ballX, ballY, ballVelX, ballVelY, ballMode);
   modport observer (input ballX, ballY, ballVelX, ballVelY, ballMode);
endinterface

// Neighbour blocks of the ball, and the kills sent back for them.
interface neighborIf;
   breakoutPkg::blockIdxT xBlock;
   breakoutPkg::blockIdxT yBlock;
   logic xAlive;
   logic yAlive;
   logic inBlockArea;
   logic canHitX;
   logic canHitY;
   breakoutPkg::blockRowT curRow;
   logic killX;
   logic killY;

   modport finder (
      output xBlock, yBlock, xAlive, yAlive, inBlockArea, canHitX, canHitY, curRow,
      input killX, killY
   );
   modport resolver (
      input xBlock, yBlock, xAlive, yAlive, inBlockArea, canHitX, canHitY, curRow,
      output killX, killY
   );
endinterface

`default_nettype wire

// File: physicsSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module physicsSequencer (
   input wire CLK,
   input wire RESET,
   input wire startUpdate,
   output breakoutPkg::physPhaseT phase
);

   // Steps already started in this frame. The last index means idle.
   logic [3:0] stepCount;

   always_ff @(posedge CLK) begin
      if (RESET) begin
         phase <= breakoutPkg::phExtrapolate;
         stepCount <= breakoutPkg::stepsPerFrame - 4'd1;
      end else begin
         case (phase)
            breakoutPkg::phExtrapolate: begin
               if (stepCount != breakoutPkg::stepsPerFrame - 4'd1) begin
                  stepCount <= stepCount + 4'd1;
                  phase <= breakoutPkg::phNeighbors;
               end else if (startUpdate) begin
                  // New frame.
                  stepCount <= 4'd0;
                  phase <= breakoutPkg::phNeighbors;
               end
            end
            breakoutPkg::phStoreY: begin
               phase <= breakoutPkg::phExtrapolate;
            end
            default: begin
               phase <= breakoutPkg::physPhaseT'(phase + 3'd1);
            end
         endcase
      end
   end

   // Every module decodes the phase, so it must stay inside the enum.
   phaseLegal: assert property (@(posedge CLK) disable iff (RESET)
      !$isunknown(phase) && phase <= breakoutPkg::phStoreY);

endmodule

`default_nettype wire

// File: ballPaddleState.sv
`timescale 1ns/1ps
`default_nettype none

module ballPaddleState (
   input wire CLK,
   input wire RESET,
   input wire breakoutPkg::physPhaseT phase,
   input wire btnLeft,
   input wire btnRight,
   input wire btnRelease,
   input wire ignoreDeath,
   input wire flipX,
   input wire flipY,
   input wire paddleHit,
   input wire breakoutPkg::posT steer,
   ballIf.owner ball,
   output breakoutPkg::pixelT paddleX,
   output logic stepComplete,
   output logic ballLostEvt
);

   breakoutPkg::posT paddleSub;
   breakoutPkg::posT movedX;
   breakoutPkg::posT clampedX;
   breakoutPkg::posT nextVelX;
   breakoutPkg::posT nextVelY;
   breakoutPkg::tileT ballTileY;
   logic lostNow;

   // Paddle motion, one speed unit per pressed button.
   always_comb begin
      movedX = paddleSub;
      if (btnRight) begin
         movedX = movedX + breakoutPkg::paddleSpeedSub;
      end
      if (btnLeft) begin
         movedX = movedX - breakoutPkg::paddleSpeedSub;
      end
      clampedX = movedX;
      if (movedX < breakoutPkg::paddleMinSub) begin
         clampedX = breakoutPkg::paddleMinSub;
      end else if (movedX > breakoutPkg::paddleMaxSub) begin
         clampedX = breakoutPkg::paddleMaxSub;
      end
   end

   always_comb begin
      nextVelX = flipX ? -ball.ballVelX : ball.ballVelX;
      nextVelY = flipY ? -ball.ballVelY : ball.ballVelY;
      // A paddle bounce takes priority over the other flips.
      if (paddleHit) begin
         nextVelX = ball.ballVelX + steer;
         nextVelY = -ball.ballVelY;
      end
   end

   assign ballTileY = breakoutPkg::tileT'(ball.ballY >> (breakoutPkg::subBits + 3));
   assign lostNow = ballTileY == breakoutPkg::lostYTile && !ignoreDeath;
   assign paddleX = paddleSub[15:breakoutPkg::subBits];

   always_ff @(posedge CLK) begin
      if (RESET) begin
         paddleSub <= breakoutPkg::paddleStartSub;
         ball.ballMode <= breakoutPkg::ballWait;
         ball.ballX <= breakoutPkg::paddleStartSub + breakoutPkg::ballParkOffsetSub;
         ball.ballY <= breakoutPkg::ballParkYSub;
         ball.ballVelX <= '0;
         ball.ballVelY <= '0;
         stepComplete <= 1'b0;
         ballLostEvt <= 1'b0;
      end else begin
         stepComplete <= phase == breakoutPkg::phUpdate;
         ballLostEvt <= phase == breakoutPkg::phUpdate &&
            ball.ballMode == breakoutPkg::ballInGame && lostNow;
         if (phase == breakoutPkg::phUpdate) begin
            paddleSub <= clampedX;
            case (ball.ballMode)
               breakoutPkg::ballWait: begin
                  // Parked centred on top of the paddle.
                  ball.ballX <= clampedX + breakoutPkg::ballParkOffsetSub;
                  ball.ballY <= breakoutPkg::ballParkYSub;
                  if (btnRelease) begin
                     ball.ballMode <= breakoutPkg::ballInGame;
                     ball.ballVelX <= breakoutPkg::launchVelX;
                     ball.ballVelY <= breakoutPkg::launchVelY;
                  end
               end
               breakoutPkg::ballInGame: begin
                  ball.ballVelX <= nextVelX;
                  ball.ballVelY <= nextVelY;
                  ball.ballX <= ball.ballX + nextVelX;
                  ball.ballY <= ball.ballY + nextVelY;
                  if (lostNow) begin
                     ball.ballMode <= breakoutPkg::ballLost;
                  end
               end
               default: begin
                  // Lost. Start over with the paddle in its home spot.
                  paddleSub <= breakoutPkg::paddleStartSub;
                  ball.ballX <= breakoutPkg::paddleStartSub + breakoutPkg::ballParkOffsetSub;
                  ball.ballY <= breakoutPkg::ballParkYSub;
                  ball.ballVelX <= '0;
                  ball.ballVelY <= '0;
                  ball.ballMode <= breakoutPkg::ballWait;
               end
            endcase
         end
      end
   end

   paddleInField: assert property (@(posedge CLK) disable iff (RESET)
      paddleX >= breakoutPkg::gameBeginXPixel &&
      paddleX <= breakoutPkg::gameEndXPixel - breakoutPkg::paddleLengthPixel);

endmodule

`default_nettype wire

// File: blockNeighborFinder.sv
`timescale 1ns/1ps
`default_nettype none

module blockNeighborFinder (
   input wire CLK,
   input wire breakoutPkg::physPhaseT phase,
   ballIf.observer ball,
   neighborIf.finder nbr,
   output breakoutPkg::blockIdxT ramAddr,
   output logic ramWrData,
   output logic ramWrEn,
   input wire ramRdData
);

   breakoutPkg::pixelT xPix;
   breakoutPkg::pixelT yPix;
   breakoutPkg::pixelT endXPix;
   breakoutPkg::pixelT endYPix;
   breakoutPkg::tileT cXTile;
   breakoutPkg::tileT cYTile;
   breakoutPkg::tileT xOff;
   breakoutPkg::tileT yOff;
   breakoutPkg::blockIdxT xAddr;
   breakoutPkg::blockIdxT yAddr;
   logic [3:0] xCol;
   logic [3:0] nbrCol;
   logic [5:0] yRow;
   logic [5:0] nbrRow;
   logic goesLeft;
   logic goesUp;

   assign goesLeft = ball.ballVelX[15];
   assign goesUp = ball.ballVelY[15];
   assign xPix = ball.ballX[15:breakoutPkg::subBits];
   assign yPix = ball.ballY[15:breakoutPkg::subBits];
   assign endXPix = xPix + breakoutPkg::ballSizePixel - 10'd1;
   assign endYPix = yPix + breakoutPkg::ballSizePixel - 10'd1;

   // Column and row of the candidate tile. Offsets left of or above the grid
   // wrap around, so the neighbour step brings them back to column or row 0.
   assign xOff = cXTile - breakoutPkg::blockStartXTile;
   assign yOff = cYTile - breakoutPkg::blockStartYTile;
   assign xCol = xOff[6:3];
   assign yRow = yOff[6:1];
   assign nbrCol = goesLeft ? xCol - 4'd1 : xCol + 4'd1;
   assign nbrRow = goesUp ? yRow - 6'd1 : yRow + 6'd1;

   always_comb begin
      xAddr = breakoutPkg::invalidBlock;
      yAddr = breakoutPkg::invalidBlock;
      if (yRow < breakoutPkg::blockRowCount && nbrCol < breakoutPkg::blockColCount) begin
         xAddr = breakoutPkg::blockIdxT'(yRow[2:0]) * breakoutPkg::blockColCount +
            breakoutPkg::blockIdxT'(nbrCol);
      end
      if (nbrRow < breakoutPkg::blockRowCount && xCol < breakoutPkg::blockColCount) begin
         yAddr = breakoutPkg::blockIdxT'(nbrRow[2:0]) * breakoutPkg::blockColCount +
            breakoutPkg::blockIdxT'(xCol);
      end
   end

   always_ff @(posedge CLK) begin
      case (phase)
         breakoutPkg::phExtrapolate: begin
            // Tile the ball fully occupies, and whether its leading edge
            // sits right against a block edge.
            cXTile <= goesLeft ? endXPix[9:3] : xPix[9:3];
            cYTile <= goesUp ? endYPix[9:3] : yPix[9:3];
            nbr.canHitX <= xPix[2:0] == 3'd0 && (goesLeft ?
               xPix[5:3] == breakoutPkg::blockStartXTile[2:0] :
               xPix[5:3] == breakoutPkg::blockStartXTile[2:0] - 3'd1);
            nbr.canHitY <= yPix[2:0] == 3'd0 &&
               (yPix[3] == breakoutPkg::blockStartYTile[0]) == goesUp;
         end
         breakoutPkg::phNeighbors: begin
            nbr.xBlock <= xAddr;
            nbr.yBlock <= yAddr;
            nbr.curRow <= yRow[2:0];
            nbr.inBlockArea <= yRow < breakoutPkg::blockRowCount ||
               (&yRow && !goesUp) || (yRow == breakoutPkg::blockRowCount && goesUp);
         end
         breakoutPkg::phLoadX: nbr.xAlive <= ramRdData;
         breakoutPkg::phLoadY: nbr.yAlive <= ramRdData;
         default: ;
      endcase
   end

   // Memory port schedule, one access per phase.
   always_comb begin
      ramAddr = nbr.yBlock;
      ramWrData = 1'b0;
      ramWrEn = 1'b0;
      case (phase)
         breakoutPkg::phNeighbors: ramAddr = xAddr;
         breakoutPkg::phUpdate: begin
            ramAddr = nbr.xBlock;
            ramWrData = nbr.xAlive && !nbr.killX;
            ramWrEn = 1'b1;
         end
         breakoutPkg::phStoreY: begin
            ramWrData = nbr.yAlive && !nbr.killY;
            ramWrEn = 1'b1;
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

// File: blockStateRam.sv
`timescale 1ns/1ps
`default_nettype none

module blockStateRam (
   input wire CLK,
   input wire breakoutPkg::blockIdxT aAddr,
   input wire aWrData,
   input wire aWrEn,
   output logic aRdData,
   input wire breakoutPkg::blockIdxT bAddr,
   output logic bRdData
);

   // One alive bit per block. The top entry is the spare and stays dead.
   logic [breakoutPkg::invalidBlock:0] alive = {1'b0, {72{1'b1}}};

   always_ff @(posedge CLK) begin
      if (aWrEn) begin
         alive[aAddr] <= aWrData;
      end
      aRdData <= alive[aAddr];
   end

   // Display port. Addresses past the spare read as dead.
   always_ff @(posedge CLK) begin
      bRdData <= bAddr <= breakoutPkg::invalidBlock && alive[bAddr];
   end

   spareStaysDead: assert property (@(posedge CLK)
      aWrEn && aAddr == breakoutPkg::invalidBlock |-> !aWrData);

endmodule

`default_nettype wire

// File: collisionResolver.sv
`timescale 1ns/1ps
`default_nettype none

module collisionResolver (
   input wire CLK,
   input wire RESET,
   input wire breakoutPkg::physPhaseT phase,
   ballIf.observer ball,
   neighborIf.resolver nbr,
   input wire breakoutPkg::pixelT paddleX,
   output logic flipX,
   output logic flipY,
   output logic paddleHit,
   output breakoutPkg::posT steer,
   output logic hitWall,
   output logic hitPaddle,
   output logic hitBlock,
   output breakoutPkg::blockRowT hitBlockRow
);

   breakoutPkg::pixelT xPix;
   breakoutPkg::pixelT yPix;
   breakoutPkg::pixelT paddleOffset;
   breakoutPkg::tileT xTile;
   breakoutPkg::tileT yTile;
   breakoutPkg::blockRowT yNbrRow;
   logic goesLeft;
   logic goesUp;
   logic atTileX;
   logic atTileY;
   logic hitLeftWall;
   logic hitRightWall;
   logic hitCeiling;
   logic contact;
   logic hitX;
   logic hitY;

   assign goesLeft = ball.ballVelX[15];
   assign goesUp = ball.ballVelY[15];
   assign xPix = ball.ballX[15:breakoutPkg::subBits];
   assign yPix = ball.ballY[15:breakoutPkg::subBits];
   assign xTile = xPix[9:3];
   assign yTile = yPix[9:3];
   assign atTileX = xPix[2:0] == 3'd0;
   assign atTileY = yPix[2:0] == 3'd0;

   assign hitLeftWall = atTileX && goesLeft && xTile == breakoutPkg::leftWallXTile + 7'd1;
   assign hitRightWall = atTileX && !goesLeft && xTile == breakoutPkg::rightWallXTile - 7'd1;
   assign hitCeiling = atTileY && goesUp && yTile == breakoutPkg::ceilingYTile + 7'd1;

   // Right edge of the ball relative to the paddle. Wraps when left of it.
   assign paddleOffset = xPix + breakoutPkg::ballSizePixel - 10'd1 - paddleX;
   assign contact = atTileY && !goesUp && yTile == breakoutPkg::paddleYTile - 7'd1 &&
      paddleOffset < breakoutPkg::paddleLengthPixel + breakoutPkg::ballSizePixel - 10'd1;

   assign hitX = nbr.inBlockArea && nbr.canHitX && nbr.xAlive;
   assign hitY = nbr.inBlockArea && nbr.canHitY && nbr.yAlive;
   assign yNbrRow = goesUp ? nbr.curRow - 3'd1 : nbr.curRow + 3'd1;

   always_ff @(posedge CLK) begin
      if (RESET) begin
         flipX <= 1'b0;
         flipY <= 1'b0;
         paddleHit <= 1'b0;
         steer <= '0;
         nbr.killX <= 1'b0;
         nbr.killY <= 1'b0;
         hitWall <= 1'b0;
         hitPaddle <= 1'b0;
         hitBlock <= 1'b0;
         hitBlockRow <= '0;
      end else if (phase == breakoutPkg::phCollide) begin
         flipX <= hitLeftWall || hitRightWall || hitX;
         flipY <= hitCeiling || hitY;
         paddleHit <= contact && ball.ballMode == breakoutPkg::ballInGame;
         // Outer quarters of the paddle steer the ball sideways.
         if (paddleOffset < breakoutPkg::paddleLengthPixel / 4 +
               breakoutPkg::ballSizePixel / 2 - 10'd1) begin
            steer <= -breakoutPkg::paddleSteerSub;
         end else if (paddleOffset >= breakoutPkg::paddleLengthPixel * 3 / 4 +
               breakoutPkg::ballSizePixel / 2 - 10'd1) begin
            steer <= breakoutPkg::paddleSteerSub;
         end else begin
            steer <= '0;
         end
         nbr.killX <= hitX;
         nbr.killY <= hitY;
         hitWall <= hitLeftWall || hitRightWall || hitCeiling;
         hitPaddle <= contact && ball.ballMode == breakoutPkg::ballInGame;
         hitBlock <= hitX || hitY;
         if (hitY) begin
            hitBlockRow <= yNbrRow;
         end else if (hitX) begin
            hitBlockRow <= nbr.curRow;
         end
      end else if (phase == breakoutPkg::phStoreY) begin
         hitWall <= 1'b0;
         hitPaddle <= 1'b0;
         hitBlock <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: breakoutPhysics.sv
`timescale 1ns/1ps
`default_nettype none

module breakoutPhysics (
   input wire CLK,
   input wire RESET,
   input wire START_UPDATE,
   input wire BTN_LEFT,
   input wire BTN_RIGHT,
   input wire BTN_RELEASE,
   input wire SW_IGNORE_DEATH,
   input wire breakoutPkg::blockIdxT BLOCK_ADDR,
   output logic STEP_COMPLETE,
   output logic HIT_WALL,
   output logic HIT_PADDLE,
   output logic HIT_BLOCK,
   output breakoutPkg::blockRowT HIT_BLOCK_ROW,
   output logic BALL_LOST,
   output breakoutPkg::pixelT PADDLE_X_PIXEL,
   output breakoutPkg::pixelT BALL_X_PIXEL,
   output breakoutPkg::pixelT BALL_Y_PIXEL,
   output logic BLOCK_ALIVE
);

   breakoutPkg::physPhaseT phase;
   breakoutPkg::blockIdxT ramAddr;
   breakoutPkg::posT steer;
   logic ramWrData;
   logic ramWrEn;
   logic ramRdData;
   logic flipX;
   logic flipY;
   logic paddleHit;

   ballIf ballBus ();
   neighborIf nbrBus ();

   physicsSequencer seq (
      .CLK(CLK),
      .RESET(RESET),
      .startUpdate(START_UPDATE),
      .phase(phase)
   );

   ballPaddleState ballState (
      .CLK(CLK),
      .RESET(RESET),
      .phase(phase),
      .btnLeft(BTN_LEFT),
      .btnRight(BTN_RIGHT),
      .btnRelease(BTN_RELEASE),
      .ignoreDeath(SW_IGNORE_DEATH),
      .flipX(flipX),
      .flipY(flipY),
      .paddleHit(paddleHit),
      .steer(steer),
      .ball(ballBus.owner),
      .paddleX(PADDLE_X_PIXEL),
      .stepComplete(STEP_COMPLETE),
      .ballLostEvt(BALL_LOST)
   );

   blockNeighborFinder finder (
      .CLK(CLK),
      .phase(phase),
      .ball(ballBus.observer),
      .nbr(nbrBus.finder),
      .ramAddr(ramAddr),
      .ramWrData(ramWrData),
      .ramWrEn(ramWrEn),
      .ramRdData(ramRdData)
   );

   blockStateRam blockRam (
      .CLK(CLK),
      .aAddr(ramAddr),
      .aWrData(ramWrData),
      .aWrEn(ramWrEn),
      .aRdData(ramRdData),
      .bAddr(BLOCK_ADDR),
      .bRdData(BLOCK_ALIVE)
   );

   collisionResolver resolver (
      .CLK(CLK),
      .RESET(RESET),
      .phase(phase),
      .ball(ballBus.observer),
      .nbr(nbrBus.resolver),
      .paddleX(PADDLE_X_PIXEL),
      .flipX(flipX),
      .flipY(flipY),
      .paddleHit(paddleHit),
      .steer(steer),
      .hitWall(HIT_WALL),
      .hitPaddle(HIT_PADDLE),
      .hitBlock(HIT_BLOCK),
      .hitBlockRow(HIT_BLOCK_ROW)
   );

   // Whole pixels of the ball position.
   assign BALL_X_PIXEL = ballBus.ballX[15:breakoutPkg::subBits];
   assign BALL_Y_PIXEL = ballBus.ballY[15:breakoutPkg::subBits];

endmodule

`default_nettype wire

// File: tbBreakout.sv
`timescale 1ns/1ps
`default_nettype none

module tbBreakout;

   // Game rules in whole pixels and subpixels per step.
   localparam int paddleHome = 370;
   localparam int paddleMin = 16;
   localparam int paddleMax = 560;
   localparam int parkOffset = 28;
   localparam int parkY = 432;
   localparam int pixelsPerFrame = 6;
   localparam int stepsPerFrame = 12;
   localparam int launchVelX = 6;
   localparam int launchRise = 16;
   localparam int blockCount = 72;
   localparam int blockCols = 9;
   localparam int blockRows = 8;

   // Run length, used to size the timeout.
   localparam int rowCount = 7;
   localparam int tableFrames = 142;
   localparam int longFrames = 400;
   localparam int lossFrameLimit = 700;
   localparam int gapCycles = 10;
   localparam int frameCycles = 7 * stepsPerFrame + gapCycles + 2;
   localparam int scanCycles = 2 * (blockCount + 1);
   localparam int timeoutCycles =
      (tableFrames + longFrames + lossFrameLimit + 1) * frameCycles + scanCycles + 200;

   typedef struct packed {
      logic left;
      logic right;
      logic launch;
      logic ignoreDeath;
      logic [7:0] frames;
      logic [9:0] paddle;
   } rowT;

   logic CLK = 1'b0;
   logic RESET;
   logic START_UPDATE;
   logic BTN_LEFT;
   logic BTN_RIGHT;
   logic BTN_RELEASE;
   logic SW_IGNORE_DEATH;
   logic [6:0] BLOCK_ADDR;
   logic STEP_COMPLETE;
   logic HIT_WALL;
   logic HIT_PADDLE;
   logic HIT_BLOCK;
   logic [2:0] HIT_BLOCK_ROW;
   logic BALL_LOST;
   logic [9:0] PADDLE_X_PIXEL;
   logic [9:0] BALL_X_PIXEL;
   logic [9:0] BALL_Y_PIXEL;
   logic BLOCK_ALIVE;

   rowT rows [rowCount];
   int unsigned lcgState = 68;
   int cycleCount = 0;
   int blockHits = 0;
   int rowHits [blockRows];
   int deadInRow [blockRows];
   int lostCount = 0;
   int restoredCount = 0;
   int expPaddle;
   int lastY;
   logic prevHitBlock = 1'b0;
   logic restorePending = 1'b0;
   logic frameHit = 1'b0;
   logic launched = 1'b0;
   logic flightClean = 1'b0;

   breakoutPhysics dut (
      .CLK(CLK),
      .RESET(RESET),
      .START_UPDATE(START_UPDATE),
      .BTN_LEFT(BTN_LEFT),
      .BTN_RIGHT(BTN_RIGHT),
      .BTN_RELEASE(BTN_RELEASE),
      .SW_IGNORE_DEATH(SW_IGNORE_DEATH),
      .BLOCK_ADDR(BLOCK_ADDR),
      .STEP_COMPLETE(STEP_COMPLETE),
      .HIT_WALL(HIT_WALL),
      .HIT_PADDLE(HIT_PADDLE),
      .HIT_BLOCK(HIT_BLOCK),
      .HIT_BLOCK_ROW(HIT_BLOCK_ROW),
      .BALL_LOST(BALL_LOST),
      .PADDLE_X_PIXEL(PADDLE_X_PIXEL),
      .BALL_X_PIXEL(BALL_X_PIXEL),
      .BALL_Y_PIXEL(BALL_Y_PIXEL),
      .BLOCK_ALIVE(BLOCK_ALIVE)
   );

   always #50 CLK = ~CLK;

   task automatic failRun(input string why);
      $display("error at %0t ns: %s", $time, why);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
         input string what);
      if (actual !== expected) begin
         $display("mismatch at %0t ns: %s, got %0d, expected %0d",
            $time, what, actual, expected);
         $display("Simulation failed");
         $fatal(1);
      end
   endtask

   always @(posedge CLK) begin
      cycleCount = cycleCount + 1;
      if (cycleCount > timeoutCycles) begin
         failRun("timeout, the run did not finish in time");
      end
   end

   function automatic int unsigned lcgNext(input int unsigned state);
      return state * 32'd1103515245 + 32'd12345;
   endfunction

   // Paddle after one frame: 6 pixels per held button, kept inside the field.
   task automatic movePaddleModel(input logic left, input logic right);
      expPaddle = expPaddle + pixelsPerFrame * (int'(right) - int'(left));
      if (expPaddle < paddleMin) begin
         expPaddle = paddleMin;
      end else if (expPaddle > paddleMax) begin
         expPaddle = paddleMax;
      end
   endtask

   task automatic checkParked();
      checkValue(BALL_X_PIXEL, PADDLE_X_PIXEL + parkOffset, "parked ball x");
      checkValue(BALL_Y_PIXEL, parkY, "parked ball y");
   endtask

   // Sampled once per cycle on the falling edge.
   task automatic watchEvents();
      if (HIT_BLOCK && !prevHitBlock) begin
         blockHits++;
         rowHits[HIT_BLOCK_ROW]++;
      end
      if (HIT_WALL || HIT_PADDLE || HIT_BLOCK) begin
         frameHit = 1'b1;
      end
      if (BALL_LOST) begin
         checkValue(STEP_COMPLETE, 1, "BALL_LOST alongside STEP_COMPLETE");
         lostCount++;
      end
      if (STEP_COMPLETE) begin
         // The step after a loss puts the paddle home and parks the ball.
         if (restorePending) begin
            checkValue(PADDLE_X_PIXEL, paddleHome, "paddle after loss");
            checkValue(BALL_X_PIXEL, paddleHome + parkOffset, "ball x after loss");
            checkValue(BALL_Y_PIXEL, parkY, "ball y after loss");
            restoredCount++;
         end
         restorePending = BALL_LOST;
      end
      prevHitBlock = HIT_BLOCK;
   endtask

   task automatic runFrame(input logic pokeStart);
      int pulses;
      logic pokeNow;
      pulses = 0;
      pokeNow = 1'b0;
      frameHit = 1'b0;
      @(posedge CLK);
      START_UPDATE <= 1'b1;
      while (pulses < stepsPerFrame) begin
         @(posedge CLK);
         // A start in mid frame must be ignored.
         START_UPDATE <= pokeNow;
         pokeNow = 1'b0;
         @(negedge CLK);
         watchEvents();
         if (STEP_COMPLETE) begin
            pulses++;
            pokeNow = pokeStart && pulses == 6;
         end
      end
      repeat (gapCycles) begin
         @(posedge CLK);
         @(negedge CLK);
         watchEvents();
         checkValue(STEP_COMPLETE, 0, "STEP_COMPLETE after the last step of a frame");
      end
   endtask

   // Until the first hit the ball rises 3 pixels per frame.
   task automatic trackFlight();
      if (flightClean) begin
         if (frameHit) begin
            flightClean = 1'b0;
         end else begin
            checkValue(BALL_Y_PIXEL, lastY - 3, "ball y in free flight");
            lastY = BALL_Y_PIXEL;
         end
      end
   endtask

   // Blocks are numbered row by row, nine to a row.
   task automatic countDeadBlocks(output int dead);
      dead = 0;
      for (int a = 0; a <= blockCount; a++) begin
         @(posedge CLK);
         BLOCK_ADDR <= 7'(a);
         @(posedge CLK);
         @(negedge CLK);
         if (a == blockCount) begin
            checkValue(BLOCK_ALIVE, 0, "spare block entry");
         end else if (!BLOCK_ALIVE) begin
            dead++;
            deadInRow[a / blockCols]++;
         end
      end
   endtask

   initial begin
      int deadCount;
      int holdFrames;
      int dir;
      int framesLeft;
      RESET = 1'b1;
      START_UPDATE = 1'b0;
      BTN_LEFT = 1'b0;
      BTN_RIGHT = 1'b0;
      BTN_RELEASE = 1'b0;
      SW_IGNORE_DEATH = 1'b0;
      BLOCK_ADDR = '0;
      // Buttons, switch, frames and paddle pixel at the end of the row.
      rows[0] = '{1'b0, 1'b1, 1'b0, 1'b0, 8'd35, 10'd560};
      rows[1] = '{1'b1, 1'b0, 1'b0, 1'b0, 8'd3, 10'd542};
      rows[2] = '{1'b1, 1'b1, 1'b0, 1'b0, 8'd2, 10'd542};
      rows[3] = '{1'b0, 1'b0, 1'b0, 1'b0, 8'd1, 10'd542};
      rows[4] = '{1'b1, 1'b0, 1'b0, 1'b0, 8'd95, 10'd16};
      rows[5] = '{1'b0, 1'b1, 1'b0, 1'b0, 8'd5, 10'd46};
      rows[6] = '{1'b0, 1'b0, 1'b1, 1'b1, 8'd1, 10'd46};
      repeat (4) @(posedge CLK);
      RESET <= 1'b0;
      @(negedge CLK);
      checkValue({STEP_COMPLETE, HIT_WALL, HIT_PADDLE, HIT_BLOCK, BALL_LOST}, 0,
         "event outputs after reset");
      checkValue(PADDLE_X_PIXEL, paddleHome, "paddle after reset");
      checkParked();
      expPaddle = paddleHome;

      for (int r = 0; r < rowCount; r++) begin
         @(posedge CLK);
         BTN_LEFT <= rows[r].left;
         BTN_RIGHT <= rows[r].right;
         BTN_RELEASE <= rows[r].launch;
         SW_IGNORE_DEATH <= rows[r].ignoreDeath;
         for (int f = 0; f < rows[r].frames; f++) begin
            runFrame(r == 2 && f == 0);
            movePaddleModel(rows[r].left, rows[r].right);
            checkValue(PADDLE_X_PIXEL, expPaddle, "paddle after a frame");
            if (launched) begin
               trackFlight();
            end else if (rows[r].launch) begin
               // Launch happens in the first step, then 11 steps of flight.
               checkValue(BALL_X_PIXEL, ((expPaddle + parkOffset) * 64 +
                  (stepsPerFrame - 1) * launchVelX) / 64, "ball x after launch");
               checkValue(BALL_Y_PIXEL, (parkY * 64 - (stepsPerFrame - 1) * launchRise) / 64,
                  "ball y after launch");
               launched = 1'b1;
               flightClean = !frameHit;
               lastY = BALL_Y_PIXEL;
            end else begin
               checkParked();
            end
         end
         checkValue(PADDLE_X_PIXEL, rows[r].paddle, "paddle at the end of a table row");
      end

      // Paddle wanders at random while the ball flies with death ignored.
      framesLeft = longFrames;
      while (framesLeft > 0) begin
         lcgState = lcgNext(lcgState);
         holdFrames = 1 + (lcgState >> 16) % 6;
         dir = (lcgState >> 24) % 3;
         @(posedge CLK);
         BTN_LEFT <= dir == 1;
         BTN_RIGHT <= dir == 2;
         BTN_RELEASE <= 1'b0;
         while (holdFrames > 0 && framesLeft > 0) begin
            runFrame(1'b0);
            movePaddleModel(dir == 1, dir == 2);
            checkValue(PADDLE_X_PIXEL, expPaddle, "paddle while wandering");
            trackFlight();
            holdFrames--;
            framesLeft--;
         end
      end
      checkValue(lostCount, 0, "BALL_LOST pulses with death ignored");
      countDeadBlocks(deadCount);
      checkValue(deadCount, blockHits, "dead blocks against HIT_BLOCK pulses");
      checkValue(blockHits > 0, 1, "at least one block hit");
      for (int r = 0; r < blockRows; r++) begin
         checkValue(deadInRow[r], rowHits[r], "dead blocks in a row against HIT_BLOCK_ROW");
      end

      // Paddle parked at the far left, so the ball gets past it.
      @(posedge CLK);
      SW_IGNORE_DEATH <= 1'b0;
      BTN_LEFT <= 1'b1;
      BTN_RIGHT <= 1'b0;
      framesLeft = lossFrameLimit;
      while (restoredCount == 0 && framesLeft > 0) begin
         runFrame(1'b0);
         framesLeft--;
      end
      if (restoredCount == 0) begin
         failRun("the ball was never lost with the paddle at the far left");
      end else begin
         runFrame(1'b0);
         checkParked();
         checkValue(lostCount, 1, "BALL_LOST pulses in the loss run");
         $display("Simulation completed successfully");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: src.f
breakoutPkg.sv
physicsIfs.sv
physicsSequencer.sv
ballPaddleState.sv
blockNeighborFinder.sv
blockStateRam.sv
collisionResolver.sv
breakoutPhysics.sv
tbBreakout.sv
